// File: logic/audioPkg.sv
// Shared widths, frame timing, register map and bus structs, imported by every audio RTL block
package audioPkg;

    localparam int NumVoices = 8;

    typedef logic signed [15:0] sample_t;
    typedef logic [31:0]        addr_t;
    typedef logic [23:0]        regData_t;
    typedef logic [3:0]         regSel_t;

    // Register map
    localparam regSel_t RegStart   = 4'd0;  // Byte address of first sample
    localparam regSel_t RegLength  = 4'd1;  // In samples
    localparam regSel_t RegControl = 4'd2;

    // Control register bits
    localparam int CtlPlay  = 0;
    localparam int CtlLoop  = 1;
    localparam int CtlMono  = 2;
    localparam int CtlRight = 3;

    localparam int SampleBytes = 2;

    // Frame timing in aclk cycles
    localparam int BitHalfCycles = 4;
    localparam int BitsPerWord   = 16;
    localparam int FrameCycles   = 2 * BitsPerWord * 2 * BitHalfCycles;

    typedef struct packed {
        logic                 strobe;
        logic [NumVoices-1:0] voiceMask;  // One bit per voice
        regSel_t              regSel;
        regData_t             regData;
    } regWrite_t;

    typedef struct packed {
        logic  playing;
        logic  mono;
        logic  right;
        addr_t nextAddr;  // Address of next fetch
    } voiceStatus_t;

    typedef enum logic [1:0] {
        IDLE,
        SCAN,
        ADDR,
        DATA
    } fetchState_t;

endpackage

// File: logic/audioTiming.sv
// Frame timing generator, derives bit clock, word select and frame strobes from aclk by counting
`timescale 1ns/100ps

module audioTiming (
    input  logic i_aclk,
    input  logic i_aresetn,
    output logic o_bclk,
    output logic o_lrclk,
    output logic o_frameTick,
    output logic o_bitFall
);
    import audioPkg::*;

    logic [$clog2(FrameCycles)-1:0] cycleCount;

    // Free running across the whole frame
    always_ff @(posedge i_aclk) begin
        if (!i_aresetn) begin
            cycleCount  <= '0;
            o_frameTick <= 1'b0;
            o_bitFall   <= 1'b0;
        end else begin
            cycleCount <= cycleCount + 1'b1;

            // Both strobes line up with the counter wrap they predict
            o_frameTick <= (cycleCount == FrameCycles - 1);
            o_bitFall   <= (cycleCount[$clog2(BitHalfCycles):0] == '1);
        end
    end

    assign o_bclk  = cycleCount[$clog2(BitHalfCycles)];
    assign o_lrclk = cycleCount[$high(cycleCount)];  // Low for left half

endmodule

// File: logic/audioChannel.sv
// One playback voice, holds its registers and play pointer, and buffers the fetched samples
`timescale 1ns/100ps

module audioChannel #(
    parameter int VoiceIndex = 0
) (
    input  logic                   i_aclk,
    input  logic                   i_aresetn,
    input  logic                   i_frameTick,
    input  audioPkg::regWrite_t    i_regWrite,
    input  logic                   i_sampleStrobe,
    input  audioPkg::sample_t      i_sample,
    output audioPkg::voiceStatus_t o_status,
    output audioPkg::sample_t      o_sample
);
    import audioPkg::*;

    regData_t startAddr;
    regData_t sampleCount;
    regData_t playPos;
    regData_t nextPos;
    logic     playing;
    logic     looping;
    logic     mono;
    logic     right;
    logic     gotSample;  // Fetch arrived this frame
    logic     regHit;
    sample_t  pending;
    sample_t  current;

    assign regHit  = i_regWrite.strobe && i_regWrite.voiceMask[VoiceIndex];
    assign nextPos = playPos + 1'b1;

    always_ff @(posedge i_aclk) begin
        if (!i_aresetn) begin
            playing   <= 1'b0;
            looping   <= 1'b0;
            mono      <= 1'b0;
            right     <= 1'b0;
            playPos   <= '0;
            gotSample <= 1'b0;
        end else begin
            if (i_sampleStrobe && playing) begin
                if (nextPos >= sampleCount) begin
                    playPos <= '0;
                    playing <= looping;  // One-shot stops after this sample
                end else begin
                    playPos <= nextPos;
                end
            end

            // CPU write overrides the pointer update
            if (regHit && i_regWrite.regSel == RegControl) begin
                playing <= i_regWrite.regData[CtlPlay];
                looping <= i_regWrite.regData[CtlLoop];
                mono    <= i_regWrite.regData[CtlMono];
                right   <= i_regWrite.regData[CtlRight];
                if (i_regWrite.regData[CtlPlay]) begin
                    playPos <= '0;
                end
            end

            if (i_frameTick) begin
                gotSample <= 1'b0;
            end else if (i_sampleStrobe) begin
                gotSample <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_aclk) begin
        if (regHit && i_regWrite.regSel == RegStart) begin
            startAddr <= i_regWrite.regData;
        end
        if (regHit && i_regWrite.regSel == RegLength) begin
            sampleCount <= i_regWrite.regData;
        end
        if (i_sampleStrobe) begin
            pending <= i_sample;
        end
        if (i_frameTick) begin
            current <= gotSample ? pending : '0;  // Silent if nothing was fetched
        end
    end

    assign o_status = '{
        playing:  playing,
        mono:     mono,
        right:    right,
        nextAddr: addr_t'(startAddr) + addr_t'(playPos) * addr_t'(SampleBytes)
    };
    assign o_sample = current;

    // Fetcher only serves voices that were playing
    assert property (@(posedge i_aclk) disable iff (!i_aresetn) i_sampleStrobe |-> playing)
        else $error("Sample strobe for stopped voice %0d", VoiceIndex);

endmodule

// File: logic/sampleFetcher.sv
// AXI4-Lite read master, fetches one sample per playing voice at the start of each frame
`timescale 1ns/100ps

module sampleFetcher (
    input  logic                          i_aclk,
    input  logic                          i_aresetn,
    input  logic                          i_frameTick,
    input  audioPkg::voiceStatus_t        i_status [audioPkg::NumVoices],
    output logic [audioPkg::NumVoices-1:0] o_sampleStrobe,
    output audioPkg::sample_t             o_sample,
    output audioPkg::addr_t               o_araddr,
    output logic [2:0]                    o_arprot,
    output logic                          o_arvalid,
    input  logic                          i_arready,
    input  audioPkg::sample_t             i_rdata,
    input  logic [1:0]                    i_rresp,  // Not checked, data taken as is
    input  logic                          i_rvalid,
    output logic                          o_rready
);
    import audioPkg::*;

    fetchState_t                  state;
    logic [NumVoices-1:0]         playMask;
    logic [NumVoices-1:0]         roundMask;  // Voices to serve this frame
    logic [$clog2(NumVoices)-1:0] voice;
    logic                         lastVoice;

    always_comb begin
        for (int v = 0; v < NumVoices; v++) begin
            playMask[v] = i_status[v].playing;
        end
    end

    assign lastVoice = (voice == NumVoices - 1);
    assign o_arprot  = '0;

    always_ff @(posedge i_aclk) begin
        if (!i_aresetn) begin
            state          <= IDLE;
            roundMask      <= '0;
            voice          <= '0;
            o_arvalid      <= 1'b0;
            o_rready       <= 1'b0;
            o_sampleStrobe <= '0;
        end else begin
            o_sampleStrobe <= '0;
            unique case (state)
                IDLE: begin
                    if (i_frameTick) begin
                        roundMask <= playMask;
                        voice     <= '0;
                        state     <= SCAN;
                    end
                end
                SCAN: begin
                    if (roundMask[voice]) begin
                        o_arvalid <= 1'b1;
                        state     <= ADDR;
                    end else if (lastVoice) begin
                        state <= IDLE;
                    end else begin
                        voice <= voice + 1'b1;
                    end
                end
                ADDR: begin
                    if (i_arready) begin
                        o_arvalid <= 1'b0;
                        o_rready  <= 1'b1;
                        state     <= DATA;
                    end
                end
                DATA: begin
                    if (i_rvalid) begin
                        o_rready              <= 1'b0;
                        o_sampleStrobe[voice] <= 1'b1;
                        if (lastVoice) begin
                            state <= IDLE;
                        end else begin
                            voice <= voice + 1'b1;
                            state <= SCAN;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge i_aclk) begin
        if (state == SCAN && roundMask[voice]) begin
            o_araddr <= i_status[voice].nextAddr;
        end
        if (o_rready && i_rvalid) begin
            o_sample <= i_rdata;
        end
    end

    assert property (@(posedge i_aclk) disable iff (!i_aresetn)
        o_arvalid && !i_arready |=> o_arvalid && $stable(o_araddr))
        else $error("araddr changed while waiting for arready");

    // Whole round must fit in one frame
    assert property (@(posedge i_aclk) disable iff (!i_aresetn) i_frameTick |-> state == IDLE)
        else $error("Fetch round still busy at frame tick");

endmodule

// File: logic/stereoMixer.sv
// Stereo mixer, pans the voice samples, sums and saturates each side once per frame
`timescale 1ns/100ps

module stereoMixer (
    input  logic                   i_aclk,
    input  logic                   i_aresetn,
    input  logic                   i_frameTick,
    input  audioPkg::voiceStatus_t i_status [audioPkg::NumVoices],
    input  audioPkg::sample_t      i_sample [audioPkg::NumVoices],
    output audioPkg::sample_t      o_left,
    output audioPkg::sample_t      o_right
);
    import audioPkg::*;

    typedef logic signed [$bits(sample_t)+$clog2(NumVoices)-1:0] mix_t;

    logic mixNow;  // Current samples settle one cycle after tick
    mix_t sumLeft;
    mix_t sumRight;

    function automatic sample_t saturate(input mix_t sum);
        if (sum > mix_t'(32767)) begin
            return 16'sh7fff;
        end
        if (sum < mix_t'(-32768)) begin
            return 16'sh8000;
        end
        return sample_t'(sum);
    endfunction

    always_comb begin
        sumLeft  = '0;
        sumRight = '0;
        for (int v = 0; v < NumVoices; v++) begin
            if (i_status[v].mono || !i_status[v].right) begin
                sumLeft = sumLeft + mix_t'(i_sample[v]);
            end
            if (i_status[v].mono || i_status[v].right) begin
                sumRight = sumRight + mix_t'(i_sample[v]);
            end
        end
    end

    always_ff @(posedge i_aclk) begin
        if (!i_aresetn) begin
            mixNow  <= 1'b0;
            o_left  <= '0;
            o_right <= '0;
        end else begin
            mixNow <= i_frameTick;
            if (mixNow) begin
                o_left  <= saturate(sumLeft);
                o_right <= saturate(sumRight);
            end
        end
    end

endmodule

// File: logic/i2sTransmitter.sv
// I2S serializer, shifts the stereo pair out MSB first with the one-bit word select delay
`timescale 1ns/100ps

module i2sTransmitter (
    input  logic              i_aclk,
    input  logic              i_aresetn,
    input  logic              i_frameTick,
    input  logic              i_bitFall,
    input  audioPkg::sample_t i_left,
    input  audioPkg::sample_t i_right,
    output logic              o_dout
);
    import audioPkg::*;

    // Delay slot, then left word, then right word
    logic [2*BitsPerWord:0] shiftReg;

    always_ff @(posedge i_aclk) begin
        if (!i_aresetn) begin
            shiftReg <= '0;
        end else if (i_frameTick) begin
            // Right LSB of the old frame fills the delay slot
            shiftReg <= {shiftReg[2*BitsPerWord-1], i_left, i_right};
        end else if (i_bitFall) begin
            shiftReg <= {shiftReg[2*BitsPerWord-1:0], 1'b0};
        end
    end

    assign o_dout = shiftReg[2*BitsPerWord];

endmodule

// File: logic/audioSystem.sv
// Top level of the eight-voice sample playback engine, CPU register bus in, AXI reads, I2S out
`timescale 1ns/100ps

module audioSystem (
    input  logic                i_aclk,
    input  logic                i_aresetn,

    input  audioPkg::regWrite_t i_regWrite,

    // AXI4-Lite read channels
    output audioPkg::addr_t     o_araddr,
    output logic [2:0]          o_arprot,
    output logic                o_arvalid,
    input  logic                i_arready,
    input  audioPkg::sample_t   i_rdata,
    input  logic [1:0]          i_rresp,
    input  logic                i_rvalid,
    output logic                o_rready,

    // I2S
    output logic                o_bclk,
    output logic                o_lrclk,
    output logic                o_dout
);
    import audioPkg::*;

    logic                 frameTick;
    logic                 bitFall;
    logic [NumVoices-1:0] sampleStrobe;
    sample_t              fetchedSample;
    voiceStatus_t         voiceStatus [NumVoices];
    sample_t              voiceSample [NumVoices];
    sample_t              mixLeft;
    sample_t              mixRight;

    audioTiming u_timing (
        .i_aclk      (i_aclk),
        .i_aresetn   (i_aresetn),
        .o_bclk      (o_bclk),
        .o_lrclk     (o_lrclk),
        .o_frameTick (frameTick),
        .o_bitFall   (bitFall)
    );

    for (genvar v = 0; v < NumVoices; v++) begin : gVoice
        audioChannel #(
            .VoiceIndex (v)
        ) u_channel (
            .i_aclk         (i_aclk),
            .i_aresetn      (i_aresetn),
            .i_frameTick    (frameTick),
            .i_regWrite     (i_regWrite),
            .i_sampleStrobe (sampleStrobe[v]),
            .i_sample       (fetchedSample),
            .o_status       (voiceStatus[v]),
            .o_sample       (voiceSample[v])
        );
    end

    sampleFetcher u_fetcher (
        .i_aclk         (i_aclk),
        .i_aresetn      (i_aresetn),
        .i_frameTick    (frameTick),
        .i_status       (voiceStatus),
        .o_sampleStrobe (sampleStrobe),
        .o_sample       (fetchedSample),
        .o_araddr       (o_araddr),
        .o_arprot       (o_arprot),
        .o_arvalid      (o_arvalid),
        .i_arready      (i_arready),
        .i_rdata        (i_rdata),
        .i_rresp        (i_rresp),
        .i_rvalid       (i_rvalid),
        .o_rready       (o_rready)
    );

    stereoMixer u_mixer (
        .i_aclk      (i_aclk),
        .i_aresetn   (i_aresetn),
        .i_frameTick (frameTick),
        .i_status    (voiceStatus),
        .i_sample    (voiceSample),
        .o_left      (mixLeft),
        .o_right     (mixRight)
    );

    i2sTransmitter u_i2s (
        .i_aclk      (i_aclk),
        .i_aresetn   (i_aresetn),
        .i_frameTick (frameTick),
        .i_bitFall   (bitFall),
        .i_left      (mixLeft),
        .i_right     (mixRight),
        .o_dout      (o_dout)
    );

endmodule

// File: tb/audioChecker.sv
// Testbench monitor, models the voices and mixer, decodes I2S frames and checks AXI reads
`timescale 1ns/100ps

module audioChecker (
    input  logic                i_aclk,
    input  logic                i_aresetn,
    input  audioPkg::regWrite_t i_regWrite,
    input  audioPkg::addr_t     i_araddr,
    input  logic [2:0]          i_arprot,
    input  logic                i_arvalid,
    input  logic                i_arready,
    input  logic                i_rready,
    input  logic                i_rvalid,
    input  logic                i_bclk,
    input  logic                i_lrclk,
    input  logic                i_dout,
    output int                  o_dataErrors,
    output int                  o_busErrors,
    output int                  o_framesChecked
);
    import audioPkg::*;

    regData_t mStart [NumVoices];
    regData_t mLength [NumVoices];
    int       mPos [NumVoices];
    logic     mPlaying [NumVoices];
    logic     mLoop [NumVoices];
    logic     mMono [NumVoices];
    logic     mRight [NumVoices];
    logic     mGot [NumVoices];
    sample_t  mPending [NumVoices];
    sample_t  mCurrent [NumVoices];
    logic [31:0] mixPair;  // Output of the mixer register
    logic [31:0] expQ [$];  // Pairs loaded into the transmitter
    addr_t       addrQ [$];  // Expected AR addresses in order
    logic        prevLr;
    logic        prevBclk;
    logic        prevLrBit;
    logic [31:0] rxWord;
    logic        prevArvalid;
    logic        prevArready;
    addr_t       prevAraddr;
    logic        readOutstanding;  // AR accepted, R not yet taken

    function automatic sample_t memWord(input addr_t a);
        return sample_t'(a[16:1] ^ 16'h5A5A);
    endfunction

    function automatic int clip(input int s);
        if (s > 32767) begin
            return 32767;
        end
        if (s < -32768) begin
            return -32768;
        end
        return s;
    endfunction

    // Expected stereo pair from current samples and pan flags
    function automatic logic [31:0] expectedPair();
        int l;
        int r;
        l = 0;
        r = 0;
        for (int v = 0; v < NumVoices; v++) begin
            if (mMono[v] || !mRight[v]) l += int'(mCurrent[v]);
            if (mMono[v] || mRight[v]) r += int'(mCurrent[v]);
        end
        l = clip(l);
        r = clip(r);
        return {l[15:0], r[15:0]};
    endfunction

    always @(posedge i_aclk) begin
        logic [31:0] word;
        logic [31:0] exp;
        addr_t       a;
        if (!i_aresetn) begin
            for (int v = 0; v < NumVoices; v++) begin
                mPlaying[v] = 1'b0;
                mLoop[v]    = 1'b0;
                mMono[v]    = 1'b0;
                mRight[v]   = 1'b0;
                mGot[v]     = 1'b0;
                mCurrent[v] = '0;
                mPos[v]     = 0;
            end
            mixPair = '0;
            expQ.delete();
            expQ.push_back('0);  // Cleared shift register before first tick
            addrQ.delete();
            prevLr = 1'b0;
            prevBclk = 1'b0;
            prevLrBit = 1'b0;
            rxWord = '0;
            prevArvalid = 1'b0;
            prevArready = 1'b0;
            readOutstanding = 1'b0;
            o_dataErrors = 0;
            o_busErrors = 0;
            o_framesChecked = 0;
        end else begin
            if (i_regWrite.strobe) begin
                for (int v = 0; v < NumVoices; v++) begin
                    if (i_regWrite.voiceMask[v]) begin
                        if (i_regWrite.regSel == RegStart) mStart[v] = i_regWrite.regData;
                        if (i_regWrite.regSel == RegLength) mLength[v] = i_regWrite.regData;
                        if (i_regWrite.regSel == RegControl) begin
                            mPlaying[v] = i_regWrite.regData[CtlPlay];
                            mLoop[v]    = i_regWrite.regData[CtlLoop];
                            mMono[v]    = i_regWrite.regData[CtlMono];
                            mRight[v]   = i_regWrite.regData[CtlRight];
                            if (i_regWrite.regData[CtlPlay]) mPos[v] = 0;
                        end
                    end
                end
            end

            // Frame tick where word select falls
            if (!i_lrclk && prevLr) begin
                expQ.push_back(mixPair);
                for (int v = 0; v < NumVoices; v++) begin
                    mCurrent[v] = mGot[v] ? mPending[v] : '0;
                    mGot[v] = 1'b0;
                end
                mixPair = expectedPair();
                for (int v = 0; v < NumVoices; v++) begin
                    if (mPlaying[v]) begin
                        a = addr_t'(mStart[v]) + addr_t'(mPos[v]) * 2;
                        addrQ.push_back(a);
                        mPending[v] = memWord(a);
                        mGot[v] = 1'b1;
                        if (mPos[v] + 1 >= int'(mLength[v])) begin
                            mPos[v] = 0;
                            mPlaying[v] = mLoop[v];
                        end else begin
                            mPos[v]++;
                        end
                    end
                end
            end
            prevLr = i_lrclk;

            if (prevArvalid && !prevArready && !(i_arvalid && i_araddr == prevAraddr)) begin
                $display("araddr dropped or changed while waiting for arready at %0t", $time);
                o_busErrors++;
            end
            if (i_arvalid && (i_rready || i_arprot != 3'd0)) begin
                $display("Bad AR request at %0t, rready or arprot set", $time);
                o_busErrors++;
            end
            if (i_rready && !readOutstanding) begin
                $display("rready high with no read outstanding at %0t", $time);
                o_busErrors++;
            end
            if (i_rvalid && i_rready) begin
                readOutstanding = 1'b0;
            end
            if (i_arvalid && i_arready) begin
                if (readOutstanding) begin
                    $display("Second read issued before the first completed at %0t", $time);
                    o_busErrors++;
                end
                readOutstanding = 1'b1;
                if (addrQ.size() == 0) begin
                    $display("Unexpected read of %08h at %0t", i_araddr, $time);
                    o_busErrors++;
                end else begin
                    a = addrQ.pop_front();
                    if (a !== i_araddr) begin
                        $display("FAIL %0t araddr expected %08h actual %08h", $time, a, i_araddr);
                        o_busErrors++;
                    end
                end
            end
            prevArvalid = i_arvalid;
            prevArready = i_arready;
            prevAraddr = i_araddr;

            // Rising bit clock samples the data line
            if (i_bclk && !prevBclk) begin
                word = {rxWord[30:0], i_dout};
                rxWord = word;
                if (!i_lrclk && prevLrBit) begin
                    if (expQ.size() == 0) begin
                        $display("Decoded a frame with no expected pair at %0t", $time);
                        o_dataErrors++;
                    end else begin
                        exp = expQ.pop_front();
                        o_framesChecked++;
                        if (exp[31:16] !== word[31:16]) begin
                            $display("FAIL %0t left expected %0d actual %0d", $time,
                                $signed(exp[31:16]), $signed(word[31:16]));
                            o_dataErrors++;
                        end
                        if (exp[15:0] !== word[15:0]) begin
                            $display("FAIL %0t right expected %0d actual %0d", $time,
                                $signed(exp[15:0]), $signed(word[15:0]));
                            o_dataErrors++;
                        end
                    end
                end
                prevLrBit = i_lrclk;
            end
            prevBclk = i_bclk;
        end
    end

endmodule

// File: tb/tbAudioSystem.sv
// Testbench top for the playback engine, drives CPU writes and models AXI memory with stalls
`timescale 1ns/100ps

module tbAudioSystem;
    import audioPkg::*;

    logic      aclk;
    logic      aresetn;
    regWrite_t regWrite;
    addr_t     araddr;
    logic [2:0] arprot;
    logic      arvalid;
    logic      arready;
    sample_t   rdata;
    logic [1:0] rresp;
    logic      rvalid;
    logic      rready;
    logic      bclk;
    logic      lrclk;
    logic      dout;
    int        dataErrors;
    int        busErrors;
    int        framesChecked;
    int        timeoutErrors;
    logic      arFire;
    logic      rFire;
    logic      arArmed;
    logic      rPending;
    int        arDelay;
    int        rDelay;
    addr_t     readAddr;

    audioSystem u_dut (
        .i_aclk     (aclk),
        .i_aresetn  (aresetn),
        .i_regWrite (regWrite),
        .o_araddr   (araddr),
        .o_arprot   (arprot),
        .o_arvalid  (arvalid),
        .i_arready  (arready),
        .i_rdata    (rdata),
        .i_rresp    (rresp),
        .i_rvalid   (rvalid),
        .o_rready   (rready),
        .o_bclk     (bclk),
        .o_lrclk    (lrclk),
        .o_dout     (dout)
    );

    audioChecker u_checker (
        .i_aclk          (aclk),
        .i_aresetn       (aresetn),
        .i_regWrite      (regWrite),
        .i_araddr        (araddr),
        .i_arprot        (arprot),
        .i_arvalid       (arvalid),
        .i_arready       (arready),
        .i_rready        (rready),
        .i_rvalid        (rvalid),
        .i_bclk          (bclk),
        .i_lrclk         (lrclk),
        .i_dout          (dout),
        .o_dataErrors    (dataErrors),
        .o_busErrors     (busErrors),
        .o_framesChecked (framesChecked)
    );

    always #10 aclk = ~aclk;

    function automatic sample_t readMemory(input addr_t a);
        return sample_t'(a[16:1] ^ 16'h5A5A);
    endfunction

    always @(posedge aclk) begin
        arFire <= arvalid && arready;
        rFire  <= rvalid && rready;
        if (arvalid && arready) readAddr <= araddr;
    end

    // Memory slave with 0 to 3 cycle stalls on both channels
    always @(negedge aclk) begin
        if (!aresetn) begin
            arready  = 1'b0;
            rvalid   = 1'b0;
            arArmed  = 1'b0;
            rPending = 1'b0;
        end else begin
            if (arFire) begin
                arready  = 1'b0;
                arArmed  = 1'b0;
                rPending = 1'b1;
                rDelay   = $urandom_range(3, 0);
            end else if (arvalid && !arready) begin
                if (!arArmed) begin
                    arArmed = 1'b1;
                    arDelay = $urandom_range(3, 0);
                end
                if (arDelay == 0) arready = 1'b1;
                else arDelay--;
            end
            if (rFire) begin
                rvalid = 1'b0;
            end else if (rPending && rready && !rvalid) begin
                if (rDelay == 0) begin
                    rvalid   = 1'b1;
                    rdata    = readMemory(readAddr);
                    rPending = 1'b0;
                end else begin
                    rDelay--;
                end
            end
        end
    end

    task automatic waitFrames(input int n);
        int seen;
        int cycles;
        logic lastLr;
        seen = 0;
        cycles = 0;
        lastLr = lrclk;
        while (seen < n) begin
            @(posedge aclk);
            if (!lrclk && lastLr) seen++;
            lastLr = lrclk;
            cycles++;
            if (cycles > (n + 1) * FrameCycles) begin
                $display("Timed out waiting for %0d frames", n);
                timeoutErrors++;
                return;
            end
        end
    endtask

    // Second half of the frame, fetch round is over
    task automatic waitRightHalf();
        int cycles;
        cycles = 0;
        while (!lrclk) begin
            @(posedge aclk);
            cycles++;
            if (cycles > FrameCycles) begin
                $display("Timed out waiting for word select to rise");
                timeoutErrors++;
                return;
            end
        end
    endtask

    task automatic writeReg(input logic [7:0] mask, input regSel_t sel, input regData_t data);
        @(negedge aclk);
        regWrite = '{strobe: 1'b1, voiceMask: mask, regSel: sel, regData: data};
        @(negedge aclk);
        regWrite = '0;
    endtask

    task automatic startVoices(input logic [7:0] mask, input regData_t start,
                               input regData_t len, input regData_t ctl);
        writeReg(mask, RegStart, start);
        writeReg(mask, RegLength, len);
        writeReg(mask, RegControl, ctl);
    endtask

    task automatic finishRun();
        $display("Errors: data %0d, bus %0d, timeout %0d, frames checked %0d",
            dataErrors, busErrors, timeoutErrors, framesChecked);
        if (dataErrors + busErrors + timeoutErrors == 0 && framesChecked > 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    initial begin
        void'($urandom(32'h9480_17c6));
        aclk = 1'b0;
        aresetn = 1'b0;
        regWrite = '0;
        arready = 1'b0;
        rvalid = 1'b0;
        rdata = '0;
        rresp = 2'b00;
        timeoutErrors = 0;
        repeat (4) @(negedge aclk);
        aresetn = 1'b1;

        waitFrames(3);  // Silence, no reads
        waitRightHalf();
        startVoices(8'h01, 24'h001000, 24'd100, 24'h5);  // Mono
        waitFrames(6);

        waitRightHalf();
        writeReg(8'h01, RegControl, 24'h0);
        startVoices(8'h02, 24'h002000, 24'd50, 24'h1);  // Left only
        startVoices(8'h04, 24'h003000, 24'd50, 24'h9);  // Right only
        waitFrames(5);

        waitRightHalf();
        writeReg(8'hFF, RegControl, 24'h0);
        startVoices(8'h0F, 24'h004000, 24'd40, 24'h5);  // Saturates high
        waitFrames(4);
        waitRightHalf();
        writeReg(8'h0F, RegControl, 24'h0);
        startVoices(8'hF0, 24'h01A000, 24'd40, 24'h5);  // Saturates low
        waitFrames(4);

        waitRightHalf();
        writeReg(8'hFF, RegControl, 24'h0);
        startVoices(8'h01, 24'h000800, 24'd3, 24'h5);  // One shot
        startVoices(8'h02, 24'h000C00, 24'd4, 24'hB);  // Looping, right
        waitFrames(8);

        waitRightHalf();
        for (int v = 0; v < NumVoices; v++) begin
            startVoices(8'(1 << v), regData_t'($urandom) & 24'hFFFFFE,
                regData_t'(1 + $urandom % 20), regData_t'(1 | ($urandom & 4'hE)));
        end
        waitFrames(10);

        waitRightHalf();
        writeReg(8'hFF, RegControl, 24'h0);
        waitFrames(3);
        @(negedge aclk);
        finishRun();
    end

endmodule

// File: list.f
logic/audioPkg.sv
logic/audioTiming.sv
logic/audioChannel.sv
logic/sampleFetcher.sv
logic/stereoMixer.sv
logic/i2sTransmitter.sv
logic/audioSystem.sv
tb/audioChecker.sv
tb/tbAudioSystem.sv

// File: Bender.yml
package:
  name: audio_system

sources:
  - logic/audioPkg.sv
  - logic/audioTiming.sv
  - logic/audioChannel.sv
  - logic/sampleFetcher.sv
  - logic/stereoMixer.sv
  - logic/i2sTransmitter.sv
  - logic/audioSystem.sv
  - target: test
    files:
      - tb/audioChecker.sv
      - tb/tbAudioSystem.sv
